// File: verilog/up_pkg.sv
`default_nettype none

package up_pkg;

   // ====================
   // Widths
   // ====================
   localparam int BYTE_W      = 8;
   localparam int NIBBLE_W    = 4;
   localparam int HOST_ADDR_W = 9;
   localparam int MEM_DEPTH   = 256;

   typedef logic [BYTE_W-1:0]      byte_t;
   typedef logic [NIBBLE_W-1:0]    nibble_t;
   typedef logic [2:0]             reg_sel_t;
   typedef logic [HOST_ADDR_W-1:0] host_addr_t;

   // ====================
   // Encodings
   // ====================
   // Values 8, 9 and 15 are left unnamed and execute as no-ops.
   typedef enum logic [3:0] {
      IR_ADD  = 4'd0,
      IR_SUB  = 4'd1,
      IR_MUL  = 4'd2,
      IR_NAND = 4'd3,
      IR_SW01 = 4'd4,
      IR_SW12 = 4'd5,
      IR_SW23 = 4'd6,
      IR_BE   = 4'd7,
      IR_POP  = 4'd10,
      IR_PUSH = 4'd11,
      IR_LDW  = 4'd12,
      IR_STW  = 4'd13,
      IR_REF  = 4'd14
   } opcode_e;

   // Arithmetic and swap selects equal the opcode with a zero on top.
   typedef enum logic [4:0] {
      OP_ADD     = 5'b00000,
      OP_SUB     = 5'b00001,
      OP_MUL     = 5'b00010,
      OP_NAND    = 5'b00011,
      OP_XOR_01  = 5'b00100,
      OP_XOR_12  = 5'b00101,
      OP_XOR_23  = 5'b00110,
      OP_SP_INC  = 5'b01000,
      OP_00      = 5'b01110,
      OP_01      = 5'b10001,
      OP_02      = 5'b10010,
      OP_03      = 5'b10011,
      OP_PC_0    = 5'b10100,
      OP_PC_INC  = 5'b10101,
      OP_R3      = 5'b10110,
      OP_IN_OUT  = 5'b11000,
      OP_SP      = 5'b11001,
      OP_SP_DEC  = 5'b11010,
      OP_PC      = 5'b11011,
      OP_R2      = 5'b11100
   } alu_sel_e;

   typedef enum logic [3:0] {
      IDLE,
      LOAD_R0,
      LOAD_R1,
      LOAD_R2,
      LOAD_R3,
      LOAD_PC,
      FETCH,
      DECODE,
      EXEC_1,
      EXEC_2,
      EXEC_3
   } state_e;

   // ====================
   // Host register map
   // ====================
   localparam host_addr_t CTRL_ADDR       = 9'h100;
   localparam int         CTRL_RUN_BIT    = 0;
   localparam int         CTRL_HALTED_BIT = 1;

endpackage

`default_nettype wire

// File: verilog/up_control.sv
`default_nettype none

module up_control (
   input  logic             clk,
   input  logic             nRst,
   input  logic             run,
   input  up_pkg::nibble_t  ir,
   input  logic             eq,
   output logic             ir_we,
   output logic             pc_we,
   output logic             sp_we,
   output logic             rb_we,
   output logic             mem_we,
   output logic             ale,
   output logic             start,
   output logic             halted,
   output up_pkg::reg_sel_t rb_sel,
   output up_pkg::alu_sel_e alu_sel
);
   import up_pkg::*;

   state_e   state;
   state_e   state_nxt;
   opcode_e  op;
   alu_sel_e op_sel;

   assign op     = opcode_e'(ir);
   assign op_sel = alu_sel_e'({1'b0, ir});
   assign halted = (state == IDLE);

   // ====================
   // Decode and next state
   // ====================
   always_comb begin
      state_nxt = state;
      ir_we     = 1'b0;
      pc_we     = 1'b0;
      sp_we     = 1'b0;
      rb_we     = 1'b0;
      mem_we    = 1'b0;
      ale       = 1'b0;
      start     = 1'b0;
      rb_sel    = 3'b100;
      alu_sel   = OP_00;
      case (state)
         IDLE: begin
            if (run) begin
               state_nxt = LOAD_R0;
            end
         end
         // Each preload step latches the next byte and stores the previous one.
         LOAD_R0: begin
            start     = 1'b1;
            ale       = 1'b1;
            state_nxt = LOAD_R1;
         end
         LOAD_R1: begin
            alu_sel   = OP_01;
            ale       = 1'b1;
            rb_we     = 1'b1;
            rb_sel    = 3'b000;
            state_nxt = LOAD_R2;
         end
         LOAD_R2: begin
            alu_sel   = OP_02;
            ale       = 1'b1;
            rb_we     = 1'b1;
            rb_sel    = 3'b001;
            state_nxt = LOAD_R3;
         end
         LOAD_R3: begin
            alu_sel   = OP_03;
            ale       = 1'b1;
            rb_we     = 1'b1;
            rb_sel    = 3'b010;
            state_nxt = LOAD_PC;
         end
         LOAD_PC: begin
            alu_sel   = OP_PC_0;
            ale       = 1'b1;
            rb_we     = 1'b1;
            rb_sel    = 3'b011;
            state_nxt = FETCH;
         end
         FETCH: begin
            if (run) begin
               alu_sel   = OP_PC_0;
               ale       = 1'b1;
               state_nxt = DECODE;
            end else begin
               state_nxt = IDLE;
            end
         end
         DECODE: begin
            alu_sel   = OP_PC_INC;
            ir_we     = 1'b1;
            pc_we     = 1'b1;
            state_nxt = EXEC_1;
         end
         EXEC_1: begin
            state_nxt = FETCH;
            case (op)
               IR_ADD, IR_SUB, IR_MUL, IR_NAND: begin
                  alu_sel = op_sel;
                  rb_we   = 1'b1;
               end
               // Swaps run three xor steps, first into the lower register.
               IR_SW01, IR_SW12, IR_SW23: begin
                  alu_sel   = op_sel;
                  rb_sel    = ir[2:0];
                  rb_we     = 1'b1;
                  state_nxt = EXEC_2;
               end
               IR_BE: begin
                  if (eq) begin
                     alu_sel = OP_R3;
                     pc_we   = 1'b1;
                  end
               end
               IR_POP: begin
                  alu_sel   = OP_SP_INC;
                  sp_we     = 1'b1;
                  ale       = 1'b1;
                  state_nxt = EXEC_2;
               end
               IR_PUSH: begin
                  alu_sel   = OP_SP;
                  ale       = 1'b1;
                  state_nxt = EXEC_2;
               end
               IR_LDW, IR_STW: begin
                  alu_sel   = OP_R3;
                  ale       = 1'b1;
                  state_nxt = EXEC_2;
               end
               IR_REF: begin
                  ale       = 1'b1;
                  state_nxt = EXEC_2;
               end
               default: begin
                  state_nxt = FETCH;
               end
            endcase
         end
         EXEC_2: begin
            state_nxt = FETCH;
            case (op)
               IR_SW01, IR_SW12, IR_SW23: begin
                  alu_sel   = op_sel;
                  rb_sel    = ir[2:0] + 3'd1;
                  rb_we     = 1'b1;
                  state_nxt = EXEC_3;
               end
               IR_PUSH: begin
                  alu_sel   = OP_SP_DEC;
                  sp_we     = 1'b1;
                  state_nxt = EXEC_3;
               end
               IR_POP, IR_LDW: begin
                  alu_sel = OP_IN_OUT;
                  rb_sel  = 3'b110;
                  rb_we   = 1'b1;
               end
               IR_STW: begin
                  alu_sel = OP_R2;
                  mem_we  = 1'b1;
               end
               IR_REF: begin
                  rb_sel = 3'b000;
                  rb_we  = 1'b1;
               end
               default: begin
                  state_nxt = FETCH;
               end
            endcase
         end
         EXEC_3: begin
            state_nxt = FETCH;
            case (op)
               IR_SW01, IR_SW12, IR_SW23: begin
                  alu_sel = op_sel;
                  rb_sel  = ir[2:0];
                  rb_we   = 1'b1;
               end
               // The address was latched from sp before the decrement.
               IR_PUSH: begin
                  alu_sel = OP_R2;
                  mem_we  = 1'b1;
               end
               default: begin
                  state_nxt = FETCH;
               end
            endcase
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // The memory latches or writes in a cycle, never both.
   a_ale_mem_we: assert property (@(posedge clk) disable iff (!nRst)
      $onehot0({ale, mem_we}));

   a_state_legal: assert property (@(posedge clk) disable iff (!nRst)
      state inside {IDLE, LOAD_R0, LOAD_R1, LOAD_R2, LOAD_R3, LOAD_PC,
                    FETCH, DECODE, EXEC_1, EXEC_2, EXEC_3});

endmodule

`default_nettype wire

// File: verilog/up_pointers.sv
`default_nettype none

module up_pointers #(
   parameter up_pkg::byte_t RESET_PC  = 8'h08,
   parameter up_pkg::byte_t STACK_TOP = 8'hFF
) (
   input  logic          clk,
   input  logic          nRst,
   input  logic          start,
   input  logic          pc_we,
   input  logic          sp_we,
   input  up_pkg::byte_t result,
   output up_pkg::byte_t pc,
   output up_pkg::byte_t sp
);

   // Program counter counts nibbles, so byte 4 high nibble is address 8.
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= RESET_PC;
      end else if (start) begin
         pc <= RESET_PC;
      end else if (pc_we) begin
         pc <= result;
      end
   end

   // Stack grows down from the top of memory.
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         sp <= STACK_TOP;
      end else if (start) begin
         sp <= STACK_TOP;
      end else if (sp_we) begin
         sp <= result;
      end
   end

   // Start comes only from the preload, where no pointer is written.
   a_start_alone: assert property (@(posedge clk) disable iff (!nRst)
      start |-> !(pc_we || sp_we));

endmodule

`default_nettype wire

// File: verilog/up_regfile.sv
`default_nettype none

module up_regfile (
   input  logic             clk,
   input  logic             nRst,
   input  logic             rb_we,
   input  logic             ir_we,
   input  up_pkg::reg_sel_t rb_sel,
   input  logic             pc_lsb,
   input  up_pkg::byte_t    result,
   input  up_pkg::byte_t    mem_data,
   output up_pkg::byte_t    r0,
   output up_pkg::byte_t    r1,
   output up_pkg::byte_t    r2,
   output up_pkg::byte_t    r3,
   output up_pkg::nibble_t  ir,
   output logic             eq
);
   import up_pkg::*;

   byte_t   regs [4];
   byte_t   wdata;
   nibble_t fetch_nib;

   // Odd pc takes the low nibble.
   assign fetch_nib = pc_lsb ? mem_data[NIBBLE_W-1:0] : mem_data[BYTE_W-1:NIBBLE_W];
   assign wdata     = rb_sel[2] ? result : mem_data;

   always_ff @(posedge clk) begin
      if (rb_we) begin
         regs[rb_sel[1:0]] <= wdata;
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         ir <= '0;
      end else if (ir_we) begin
         ir <= fetch_nib;
      end
   end

   assign r0 = regs[0];
   assign r1 = regs[1];
   assign r2 = regs[2];
   assign r3 = regs[3];
   assign eq = (r1 == r2);

   // Program bytes must have been loaded before they are fetched.
   a_fetch_known: assert property (@(posedge clk) disable iff (!nRst)
      ir_we |-> !$isunknown(fetch_nib));

endmodule

`default_nettype wire

// File: verilog/up_alu.sv
`default_nettype none

module up_alu (
   input  up_pkg::alu_sel_e alu_sel,
   input  up_pkg::byte_t    r0,
   input  up_pkg::byte_t    r1,
   input  up_pkg::byte_t    r2,
   input  up_pkg::byte_t    r3,
   input  up_pkg::byte_t    pc,
   input  up_pkg::byte_t    sp,
   input  up_pkg::byte_t    mem_data,
   output up_pkg::byte_t    result
);
   import up_pkg::*;

   always_comb begin
      case (alu_sel)
         // Arithmetic wraps modulo 256.
         OP_ADD:    result = r1 + r2;
         OP_SUB:    result = r1 - r2;
         OP_MUL:    result = r1 * r2;
         OP_NAND:   result = ~(r1 & r2);
         OP_XOR_01: result = r0 ^ r1;
         OP_XOR_12: result = r1 ^ r2;
         OP_XOR_23: result = r2 ^ r3;
         // Constants address the preload bytes.
         OP_00:     result = 8'h00;
         OP_01:     result = 8'h01;
         OP_02:     result = 8'h02;
         OP_03:     result = 8'h03;
         // Byte address of the current nibble.
         OP_PC_0:   result = {1'b0, pc[BYTE_W-1:1]};
         OP_PC_INC: result = pc + 8'd1;
         OP_SP_INC: result = sp + 8'd1;
         OP_SP:     result = sp;
         OP_SP_DEC: result = sp - 8'd1;
         OP_R2:     result = r2;
         OP_R3:     result = r3;
         OP_IN_OUT: result = mem_data;
         default:   result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/up_memory.sv
`default_nettype none

module up_memory (
   input  logic               clk,
   input  logic               nRst,
   input  logic               ale,
   input  logic               mem_we,
   input  logic               halted,
   input  up_pkg::byte_t      result,
   output up_pkg::byte_t      mem_data,
   output logic               run,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  up_pkg::host_addr_t paddr,
   input  up_pkg::byte_t      pwdata,
   output up_pkg::byte_t      prdata,
   output logic               pready,
   output logic               pslverr
);
   import up_pkg::*;

   byte_t mem [MEM_DEPTH];
   byte_t addr;
   byte_t host_byte;
   byte_t ctrl_rd;
   logic  access;
   logic  is_ctrl;
   logic  mem_ok;

   assign mem_data = mem[addr];

   // ====================
   // APB host port
   // ====================
   assign host_byte = paddr[BYTE_W-1:0];
   assign access    = psel & penable;
   assign is_ctrl   = paddr[HOST_ADDR_W-1];
   assign mem_ok    = halted & ~is_ctrl;

   // No wait states. Memory is only open to the host while the core is halted.
   assign pready  = 1'b1;
   assign pslverr = access & ~is_ctrl & ~halted;

   always_comb begin
      ctrl_rd                  = '0;
      ctrl_rd[CTRL_RUN_BIT]    = run;
      ctrl_rd[CTRL_HALTED_BIT] = halted;
   end

   assign prdata = is_ctrl ? ctrl_rd : (mem_ok ? mem[host_byte] : '0);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         addr <= '0;
         run  <= 1'b0;
      end else begin
         if (ale) begin
            addr <= result;
         end
         if (access && pwrite && is_ctrl) begin
            run <= pwdata[CTRL_RUN_BIT];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[addr] <= result;
      end else if (access && pwrite && mem_ok) begin
         mem[host_byte] <= pwdata;
      end
   end

   // Halted is driven by the sequencer, so host and core never share a write.
   a_no_core_write_halted: assert property (@(posedge clk) disable iff (!nRst)
      halted |-> !mem_we);

endmodule

`default_nettype wire

// File: verilog/up_top.sv
`default_nettype none

module up_top #(
   parameter up_pkg::byte_t RESET_PC  = 8'h08,
   parameter up_pkg::byte_t STACK_TOP = 8'hFF
) (
   input  logic               clk,
   input  logic               nRst,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  up_pkg::host_addr_t paddr,
   input  up_pkg::byte_t      pwdata,
   output up_pkg::byte_t      prdata,
   output logic               pready,
   output logic               pslverr
);
   import up_pkg::*;

   logic     run;
   logic     halted;
   logic     ir_we;
   logic     pc_we;
   logic     sp_we;
   logic     rb_we;
   logic     mem_we;
   logic     ale;
   logic     start;
   logic     eq;
   reg_sel_t rb_sel;
   alu_sel_e alu_sel;
   nibble_t  ir;
   byte_t    pc;
   byte_t    sp;
   byte_t    r0;
   byte_t    r1;
   byte_t    r2;
   byte_t    r3;
   byte_t    result;
   byte_t    mem_data;

   up_control u_control (
      .clk     (clk),
      .nRst    (nRst),
      .run     (run),
      .ir      (ir),
      .eq      (eq),
      .ir_we   (ir_we),
      .pc_we   (pc_we),
      .sp_we   (sp_we),
      .rb_we   (rb_we),
      .mem_we  (mem_we),
      .ale     (ale),
      .start   (start),
      .halted  (halted),
      .rb_sel  (rb_sel),
      .alu_sel (alu_sel)
   );

   up_pointers #(
      .RESET_PC  (RESET_PC),
      .STACK_TOP (STACK_TOP)
   ) u_pointers (
      .clk    (clk),
      .nRst   (nRst),
      .start  (start),
      .pc_we  (pc_we),
      .sp_we  (sp_we),
      .result (result),
      .pc     (pc),
      .sp     (sp)
   );

   up_regfile u_regfile (
      .clk      (clk),
      .nRst     (nRst),
      .rb_we    (rb_we),
      .ir_we    (ir_we),
      .rb_sel   (rb_sel),
      .pc_lsb   (pc[0]),
      .result   (result),
      .mem_data (mem_data),
      .r0       (r0),
      .r1       (r1),
      .r2       (r2),
      .r3       (r3),
      .ir       (ir),
      .eq       (eq)
   );

   up_alu u_alu (
      .alu_sel  (alu_sel),
      .r0       (r0),
      .r1       (r1),
      .r2       (r2),
      .r3       (r3),
      .pc       (pc),
      .sp       (sp),
      .mem_data (mem_data),
      .result   (result)
   );

   up_memory u_memory (
      .clk      (clk),
      .nRst     (nRst),
      .ale      (ale),
      .mem_we   (mem_we),
      .halted   (halted),
      .result   (result),
      .mem_data (mem_data),
      .run      (run),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr)
   );

endmodule

`default_nettype wire

// File: include/up_tb_tasks.svh
`ifndef UP_TB_TASKS_SVH
`define UP_TB_TASKS_SVH

// ====================
// Checks
// ====================
task automatic check_byte(input string what, input byte_t got, input byte_t exp);
   checks++;
   assert (got === exp) else begin
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
   end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
   checks++;
   assert (got === exp) else begin
      $display("mismatch at %0t: %s read %b, expected %b", $time, what, got, exp);
      errors++;
   end
endtask

task automatic finish_test(input string name, input int errs_before);
   if (errors == errs_before) begin
      $display("test %s: pass", name);
   end else begin
      $display("test %s: FAIL, %0d errors", name, errors - errs_before);
   end
endtask

// ====================
// APB driver
// ====================
// The response is sampled a quarter period into the access phase.
task automatic apb_write(input host_addr_t addr, input byte_t data, output logic err);
   @(negedge clk);
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b1;
   paddr   = addr;
   pwdata  = data;
   @(negedge clk);
   penable = 1'b1;
   #(PERIOD / 4);
   err = pslverr;
   check_bit("pready on write", pready, 1'b1);
   @(negedge clk);
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apb_read(input host_addr_t addr, output byte_t data, output logic err);
   @(negedge clk);
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b0;
   paddr   = addr;
   @(negedge clk);
   penable = 1'b1;
   #(PERIOD / 4);
   data = prdata;
   err  = pslverr;
   check_bit("pready on read", pready, 1'b1);
   @(negedge clk);
   psel    = 1'b0;
   penable = 1'b0;
endtask

task automatic mem_write(input byte_t addr, input byte_t data);
   logic err;
   apb_write({1'b0, addr}, data, err);
   check_bit("pslverr on halted memory write", err, 1'b0);
endtask

task automatic mem_read(input byte_t addr, output byte_t data);
   logic err;
   apb_read({1'b0, addr}, data, err);
   check_bit("pslverr on halted memory read", err, 1'b0);
endtask

task automatic ctrl_write(input logic run_bit);
   logic err;
   apb_write(CTRL_ADDR, {7'd0, run_bit}, err);
   check_bit("pslverr on control write", err, 1'b0);
endtask

task automatic ctrl_read(output byte_t data);
   logic err;
   apb_read(CTRL_ADDR, data, err);
   check_bit("pslverr on control read", err, 1'b0);
endtask

// ====================
// Program loading and running
// ====================
function automatic int op_cycles(input nibble_t op);
   case (op)
      4'd4, 4'd5, 4'd6, 4'd11: return 5;
      4'd10, 4'd12, 4'd13, 4'd14: return 4;
      default: return 3;
   endcase
endfunction

// Bytes 0..3 preload r0..r3. Code starts at byte 4 high nibble and no-op padding follows.
task automatic load_program(input byte_t b0, input byte_t b1, input byte_t b2, input byte_t b3);
   int n;
   prog_cycles = 0;
   foreach (prog_q[i]) begin
      prog_cycles += op_cycles(prog_q[i]);
   end
   if (prog_q.size() % 2 != 0) begin
      prog_q.push_back(4'h8);
   end
   n = prog_q.size() / 2;
   mem_write(8'd0, b0);
   mem_write(8'd1, b1);
   mem_write(8'd2, b2);
   mem_write(8'd3, b3);
   for (int i = 0; i < n; i++) begin
      mem_write(byte_t'(4 + i), {prog_q[2 * i], prog_q[2 * i + 1]});
   end
   for (int i = 0; i < 8; i++) begin
      mem_write(byte_t'(4 + n + i), 8'h88);
   end
endtask

task automatic wait_halted();
   byte_t st;
   bit    seen;
   seen = 1'b0;
   for (int i = 0; i < 40 && !seen; i++) begin
      ctrl_read(st);
      seen = st[CTRL_HALTED_BIT];
   end
   checks++;
   assert (seen) else begin
      $display("error at %0t: core did not halt after run was cleared", $time);
      errors++;
   end
endtask

// Six cycles cover the IDLE exit and the register preload.
task automatic run_and_stop(input int cycles);
   ctrl_write(1'b1);
   repeat (cycles + 6) @(negedge clk);
   ctrl_write(1'b0);
   wait_halted();
endtask

// ====================
// Directed tests
// ====================
task automatic test_reset_and_host();
   int    errs;
   byte_t st;
   byte_t wr [8];
   byte_t rd;
   errs = errors;
   ctrl_read(st);
   check_byte("control after reset", st, 8'h02);
   for (int i = 0; i < 8; i++) begin
      wr[i] = byte_t'($random(seed)) ^ byte_t'(8'h50 + i);
      mem_write(byte_t'(8'h50 + i), wr[i]);
   end
   for (int i = 0; i < 8; i++) begin
      mem_read(byte_t'(8'h50 + i), rd);
      check_byte($sformatf("host byte %h", 8'h50 + i), rd, wr[i]);
   end
   finish_test("reset_and_host", errs);
endtask

// Two swaps move the result from r0 to r2 and STW stores it at r3.
task automatic test_arith();
   int    errs;
   byte_t a;
   byte_t b;
   byte_t exp;
   byte_t rd;
   errs = errors;
   for (int k = 0; k < 4; k++) begin
      a = byte_t'($random(seed));
      b = byte_t'($random(seed));
      case (k)
         0: exp = a + b;
         1: exp = a - b;
         2: exp = a * b;
         default: exp = ~(a & b);
      endcase
      prog_q = {nibble_t'(k), 4'h4, 4'h5, 4'hD};
      load_program(8'h00, a, b, byte_t'(8'h60 + k));
      run_and_stop(prog_cycles);
      mem_read(byte_t'(8'h60 + k), rd);
      check_byte($sformatf("op %0d on %h, %h", k, a, b), rd, exp);
   end
   finish_test("arith", errs);
endtask

task automatic test_swaps();
   int    errs;
   byte_t v [4];
   byte_t rd;
   errs = errors;
   for (int i = 0; i < 4; i++) begin
      v[i] = byte_t'($random(seed));
   end
   // After the three swaps r0..r3 hold v1 v2 v3 v0. The later swaps bring each value to r2.
   prog_q = {4'h4, 4'h5, 4'h6, 4'hB, 4'h5, 4'hB, 4'h4, 4'h5, 4'hB, 4'h6, 4'hB};
   load_program(v[0], v[1], v[2], v[3]);
   run_and_stop(prog_cycles);
   mem_read(8'hFF, rd);
   check_byte("stack byte ff", rd, v[3]);
   mem_read(8'hFE, rd);
   check_byte("stack byte fe", rd, v[2]);
   mem_read(8'hFD, rd);
   check_byte("stack byte fd", rd, v[1]);
   mem_read(8'hFC, rd);
   check_byte("stack byte fc", rd, v[0]);
   finish_test("swaps", errs);
endtask

task automatic test_mem_stack();
   int    errs;
   byte_t x;
   byte_t d;
   byte_t m;
   byte_t p0;
   byte_t rd;
   errs = errors;
   x  = byte_t'($random(seed));
   d  = byte_t'($random(seed));
   m  = d ^ 8'hA5;
   p0 = (x + d) ^ 8'h5A;
   mem_write(8'h70, m);
   // PUSH LDW PUSH POP POP STW ADD REF SW01 SW12 PUSH
   prog_q = {4'hB, 4'hC, 4'hB, 4'hA, 4'hA, 4'hD, 4'h0, 4'hE, 4'h4, 4'h5, 4'hB};
   load_program(p0, x, d, 8'h70);
   run_and_stop(prog_cycles);
   mem_read(8'h70, rd);
   check_byte("STW of popped value", rd, d);
   mem_read(8'hFE, rd);
   check_byte("push of loaded word", rd, m);
   mem_read(8'hFF, rd);
   check_byte("push of reloaded r0", rd, p0);
   finish_test("mem_stack", errs);
endtask

// The STW at nibble 40 lies far beyond where the untaken path gets before the stop.
task automatic test_branch(input bit equal);
   int    errs;
   byte_t v1;
   byte_t v2;
   byte_t rd;
   errs = errors;
   v1 = (byte_t'($random(seed)) & 8'h7F) | 8'h01;
   v2 = equal ? v1 : ~v1;
   prog_q = {4'h7};
   for (int i = 0; i < 31; i++) begin
      prog_q.push_back(4'h8);
   end
   prog_q.push_back(4'hD);
   mem_write(8'h28, 8'h00);
   load_program(8'h00, v1, v2, 8'h28);
   run_and_stop(op_cycles(4'h7) + op_cycles(4'hD));
   mem_read(8'h28, rd);
   check_byte(equal ? "taken branch marker" : "untaken branch marker", rd,
              equal ? v2 : 8'h00);
   finish_test(equal ? "branch_taken" : "branch_not_taken", errs);
endtask

task automatic test_host_protect();
   int    errs;
   byte_t v;
   byte_t rd;
   logic  err;
   errs = errors;
   v = byte_t'($random(seed));
   mem_write(8'h30, v);
   prog_q = {};
   for (int i = 0; i < 16; i++) begin
      prog_q.push_back(4'h8);
   end
   load_program(8'h00, 8'h00, 8'h00, 8'h00);
   ctrl_write(1'b1);
   repeat (8) @(negedge clk);
   apb_write({1'b0, 8'h30}, ~v, err);
   check_bit("pslverr on write while running", err, 1'b1);
   apb_read({1'b0, 8'h30}, rd, err);
   check_bit("pslverr on read while running", err, 1'b1);
   check_byte("prdata on rejected read", rd, 8'h00);
   ctrl_read(rd);
   check_byte("control while running", rd, 8'h01);
   ctrl_write(1'b0);
   wait_halted();
   ctrl_read(rd);
   check_byte("control after stop", rd, 8'h02);
   mem_read(8'h30, rd);
   check_byte("protected byte", rd, v);
   finish_test("host_protect", errs);
endtask

`endif

// File: tb/tb_up.sv
`default_nettype none

module tb_up;
   import up_pkg::*;

   localparam int PERIOD       = 100;
   localparam int RESET_CYCLES = 4;

   // Rough cycle cost of each test, dominated by the APB loads and the halt polls.
   localparam int HOST_TEST_CYCLES   = 60;
   localparam int ARITH_TEST_CYCLES  = 4 * 110;
   localparam int SWAP_TEST_CYCLES   = 170;
   localparam int STACK_TEST_CYCLES  = 170;
   localparam int BRANCH_TEST_CYCLES = 2 * 160;
   localparam int PROT_TEST_CYCLES   = 120;
   localparam int EST_CYCLES = RESET_CYCLES + HOST_TEST_CYCLES + ARITH_TEST_CYCLES +
                               SWAP_TEST_CYCLES + STACK_TEST_CYCLES +
                               BRANCH_TEST_CYCLES + PROT_TEST_CYCLES;
   localparam int WATCHDOG_CYCLES = 2 * EST_CYCLES + 100;

   logic       clk;
   logic       nRst;
   logic       psel;
   logic       penable;
   logic       pwrite;
   host_addr_t paddr;
   byte_t      pwdata;
   byte_t      prdata;
   logic       pready;
   logic       pslverr;

   int      seed;
   int      errors;
   int      checks;
   int      prog_cycles;
   nibble_t prog_q[$];

   up_top u_dut (
      .clk     (clk),
      .nRst    (nRst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always #(PERIOD / 2) clk = ~clk;

   `include "up_tb_tasks.svh"

   // ====================
   // Watchdog
   // ====================
   initial begin
      #(WATCHDOG_CYCLES * PERIOD);
      $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

   // ====================
   // Test sequence
   // ====================
   initial begin
      clk         = 1'b0;
      nRst        = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      seed        = 32'hfdb8_2eb6;
      errors      = 0;
      checks      = 0;
      prog_cycles = 0;

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      nRst = 1'b1;

      test_reset_and_host();
      test_arith();
      test_swaps();
      test_mem_stack();
      test_branch(1'b1);
      test_branch(1'b0);
      test_host_protect();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
verilog/up_pkg.sv
verilog/up_control.sv
verilog/up_pointers.sv
verilog/up_regfile.sv
verilog/up_alu.sv
verilog/up_memory.sv
verilog/up_top.sv
tb/tb_up.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module tb_up -o tb_up_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "build failed with status $status"
   exit 1
fi

./obj_dir/tb_up_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Everything OK" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
